// ==== src.f ====
verilog/mhq_pkg.sv
verilog/mhq_lu.sv
verilog/mhq_ex.sv
verilog/mhq_fill.sv
verilog/mhq_top.sv
verification/mhq_apb_mem.sv
verification/mhq_tb.sv

// ==== verification/mhq_apb_mem.sv ====
/* Read-only APB memory model; each word is its address XOR 32'h5a5a_0000.
   Each transfer gets 0 to 3 wait states from a fixed-seed LCG. */
`timescale 1ns/100ps

module mhq_apb_mem import mhq_pkg::*; (
    input  logic  clk,
    input  logic  n_rst,
    input  addr_t i_paddr,
    input  logic  i_psel,
    input  logic  i_penable,
    output data_t o_prdata,
    output logic  o_pready
);

    logic [31:0] lcg_state;
    logic [31:0] lcg_step;
    logic [1:0]  wait_left;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    assign lcg_step = lcg_next(lcg_state);
    assign o_prdata = {i_paddr[31:2], 2'b00} ^ 32'h5a5a_0000;
    assign o_pready = i_psel && i_penable && (wait_left == 2'd0);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            lcg_state <= 32'h810f5c60;
            wait_left <= 2'd0;
        end else if (i_psel && !i_penable) begin
            // Setup phase picks the wait states of this transfer
            lcg_state <= lcg_step;
            wait_left <= lcg_step[31:30];
        end else if (i_psel && i_penable && (wait_left != 2'd0)) begin
            wait_left <= wait_left - 2'd1;
        end
    end

endmodule

// ==== verification/mhq_cases.txt ====
# L func(0=LB 1=LH 2=LW 3=SB 4=SH 5=SW) byte_addr store_data dc_hit, all hex
# E line_addr expected_line (word 3 down to word 0), fills in allocation order
L 2 00001000 00000000 0
E 0000100 5a5a100c5a5a10085a5a10045a5a1000
L 5 00005000 11223344 0
L 3 00005001 000000aa 0
L 4 00005006 0000bbcc 0
L 3 0000500f 00000099 0
L 4 00005002 0000eeff 0
E 0000500 995a500c5a5a5008bbcc5004eeffaa44
L 0 00005008 00000000 0
L 2 00006000 00000000 1
L 5 00005004 12345678 1
L 3 00002005 000000ab 0
E 0000200 5a5a200c5a5a20085a5aab045a5a2000
L 4 0000300a 0000c0de 0
E 0000300 5a5a300cc0de30085a5a30045a5a3000
L 5 0000400c deadbeef 0
E 0000400 deadbeef5a5a40085a5a40045a5a4000
L 2 00008000 00000000 0
L 1 00009004 00000000 0
L 5 0000a008 cafef00d 0
L 0 0000b00c 00000000 0
L 3 0000c000 00000077 0
E 0000800 5a5a800c5a5a80085a5a80045a5a8000
E 0000900 5a5a900c5a5a90085a5a90045a5a9000
E 0000a00 5a5aa00ccafef00d5a5aa0045a5aa000
E 0000b00 5a5ab00c5a5ab0085a5ab0045a5ab000
E 0000c00 5a5ac00c5a5ac0085a5ac0045a5ac077

// ==== verification/mhq_tb.sv ====
/* Requests and expected fills come from verification/mhq_cases.txt.
   A request is held until the queue is not full; fills must arrive in file order. */
`timescale 1ns/100ps

module mhq_tb import mhq_pkg::*; ();

    logic       clk = 1'b0;
    logic       n_rst;
    logic       lookup_valid;
    logic       lookup_dc_hit;
    addr_t      lookup_addr;
    lsu_func_t  lookup_func;
    data_t      lookup_data;
    logic       lookup_we;
    logic       mhq_full;
    addr_t      paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    data_t      prdata;
    logic       pready;
    logic       fill_valid;
    mhq_addr_t  fill_addr;
    cacheline_t fill_data;

    logic [2:0] req_func_q[$];
    addr_t      req_addr_q[$];
    data_t      req_data_q[$];
    logic       req_hit_q[$];
    mhq_addr_t  exp_addr_q[$];
    cacheline_t exp_line_q[$];
    int         case_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    logic       full_seen = 1'b0;

    always #20 clk = ~clk;

    mhq_top u_dut (
        .clk(clk), .n_rst(n_rst),
        .i_lookup_valid(lookup_valid), .i_lookup_dc_hit(lookup_dc_hit),
        .i_lookup_addr(lookup_addr), .i_lookup_func(lookup_func),
        .i_lookup_data(lookup_data), .i_lookup_we(lookup_we), .o_mhq_full(mhq_full),
        .o_paddr(paddr), .o_psel(psel), .o_penable(penable), .o_pwrite(pwrite),
        .i_prdata(prdata), .i_pready(pready),
        .o_fill_valid(fill_valid), .o_fill_addr(fill_addr), .o_fill_data(fill_data)
    );

    mhq_apb_mem u_mem (
        .clk(clk), .n_rst(n_rst), .i_paddr(paddr), .i_psel(psel),
        .i_penable(penable), .o_prdata(prdata), .o_pready(pready)
    );

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_line_addr(input mhq_addr_t got, input mhq_addr_t expected);
        if (got !== expected) begin
            $display("ERR %0t: fill line address %h, expected %h", $time, got, expected);
            abort_run();
        end
    endtask

    task automatic check_line(input cacheline_t got, input cacheline_t expected);
        if (got !== expected) begin
            $display("ERR %0t: fill data %h, expected %h", $time, got, expected);
            abort_run();
        end
    endtask

    task automatic check_full(input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERR %0t: queue full flag %b, expected %b", $time, got, expected);
            abort_run();
        end
    endtask

    task automatic read_cases();
        int         fd;
        int         n;
        string      text;
        logic [2:0] func_bits;
        addr_t      addr;
        data_t      data;
        logic       hit;
        mhq_addr_t  line_addr;
        cacheline_t line_data;
        fd = $fopen("verification/mhq_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/mhq_cases.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            n = $fgets(text, fd);
            if ((n > 0) && (text.getc(0) == "L")) begin
                n = $sscanf(text, "L %h %h %h %h", func_bits, addr, data, hit);
                req_func_q.push_back(func_bits);
                req_addr_q.push_back(addr);
                req_data_q.push_back(data);
                req_hit_q.push_back(hit);
                case_count++;
            end else if ((n > 0) && (text.getc(0) == "E")) begin
                n = $sscanf(text, "E %h %h", line_addr, line_data);
                exp_addr_q.push_back(line_addr);
                exp_line_q.push_back(line_data);
                case_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_request(input lsu_func_t func, input addr_t addr,
                                 input data_t data, input logic hit);
        @(posedge clk);
        lookup_valid  <= 1'b1;
        lookup_func   <= func;
        lookup_addr   <= addr;
        lookup_data   <= data;
        lookup_dc_hit <= hit;
        lookup_we     <= (func == LSU_FUNC_SB) || (func == LSU_FUNC_SH) ||
                         (func == LSU_FUNC_SW);
        // The queue drops a request seen while full, so keep presenting it
        @(negedge clk);
        while (mhq_full) begin
            @(negedge clk);
        end
    endtask

    // Fills are checked mid-cycle against the next expected line
    always @(negedge clk) begin
        if (n_rst === 1'b1) begin
            if (psel && pwrite) begin
                $display("APB write seen at %0t, the fill engine must only read", $time);
                abort_run();
            end
            // The burst of distinct lines has to fill all four entries
            if (mhq_full === 1'b1) begin
                full_seen <= 1'b1;
            end
            if (fill_valid === 1'b1) begin
                if (exp_addr_q.size() == 0) begin
                    $display("Fill for line %h arrived with no fill left to expect", fill_addr);
                    abort_run();
                end else begin
                    check_line_addr(fill_addr, exp_addr_q.pop_front());
                    check_line(fill_data, exp_line_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
            $display("Timeout after %0d cycles, the expected fills did not finish", cycle_count);
            abort_run();
        end
    end

    initial begin
        n_rst         = 1'b0;
        lookup_valid  = 1'b0;
        lookup_dc_hit = 1'b0;
        lookup_addr   = '0;
        lookup_func   = LSU_FUNC_LB;
        lookup_data   = '0;
        lookup_we     = 1'b0;
        read_cases();
        cycle_limit = case_count * 64;

        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        // Empty queue out of reset
        @(negedge clk);
        check_full(mhq_full, 1'b0);

        for (int i = 0; i < req_func_q.size(); i++) begin
            drive_request(lsu_func_t'(req_func_q[i]), req_addr_q[i], req_data_q[i],
                          req_hit_q[i]);
        end
        @(posedge clk);
        lookup_valid <= 1'b0;

        while (exp_addr_q.size() != 0) begin
            @(negedge clk);
        end
        // Quiet window long enough for one more fill to show up
        repeat (32) @(negedge clk);
        // All entries have drained
        check_full(mhq_full, 1'b0);
        if (!full_seen) begin
            $display("The queue never reported full during the misses to distinct lines");
            abort_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== verilog/mhq_ex.sv ====
/* Entries are allocated at the tail and released from the head, in order.
   Full counts the allocation in flight so a request a cycle behind is dropped. */
`timescale 1ns/100ps

module mhq_ex import mhq_pkg::*; (
    input  logic                              clk,
    input  logic                              n_rst,

    input  logic                              i_lu_en,
    input  logic                              i_lu_we,
    input  dc_offset_t                        i_lu_offset,
    input  data_t                             i_lu_wr_data,
    input  byte_select_t                      i_lu_byte_select,
    input  logic                              i_lu_match,
    input  mhq_tag_t                          i_lu_tag,
    input  mhq_tag_select_t                   i_lu_tag_select,
    input  mhq_addr_t                         i_lu_addr,

    input  logic                              i_fill_release,
    input  mhq_tag_t                          i_fill_release_tag,

    output logic [MHQ_DEPTH-1:0]              o_mhq_valid,
    output mhq_addr_t [MHQ_DEPTH-1:0]         o_mhq_addr,
    output cacheline_t [MHQ_DEPTH-1:0]        o_mhq_data,
    output dc_byte_select_t [MHQ_DEPTH-1:0]   o_mhq_byte_updated,
    output mhq_tag_t                          o_mhq_tail,
    output mhq_tag_t                          o_mhq_head,
    output logic                              o_mhq_full,

    output logic                              o_ex_bypass_en,
    output mhq_addr_t                         o_ex_bypass_addr,
    output mhq_tag_select_t                   o_ex_bypass_tag_select,
    output logic                              o_ex_release_ack
);

    logic                       alloc;
    logic                       merge;
    mhq_tag_t                   write_tag;
    mhq_tag_select_t            write_select;
    dc_byte_select_t            line_select;
    cacheline_t                 line_data;
    logic [MHQ_TAG_WIDTH:0]     valid_count;

    // A match whose entry was released meanwhile becomes a fresh allocation
    assign merge     = i_lu_en && i_lu_match && o_mhq_valid[i_lu_tag];
    assign alloc     = i_lu_en && !merge;
    assign write_tag = alloc ? o_mhq_tail : i_lu_tag;

    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            write_select[i] = (mhq_tag_t'(i) == write_tag);
        end
    end

    // Move the word into its slot in the line
    always_comb begin
        line_select = '0;
        if (i_lu_we) begin
            line_select = dc_byte_select_t'(i_lu_byte_select) << {i_lu_offset[3:2], 2'b00};
        end
        line_data = cacheline_t'(i_lu_wr_data) << {i_lu_offset[3:2], 5'b00000};
    end

    always_comb begin
        valid_count = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            valid_count = valid_count + o_mhq_valid[i];
        end
    end

    assign o_mhq_full = (valid_count + alloc) >= MHQ_DEPTH;

    // Hold off the release while the same entry is being written
    assign o_ex_release_ack = i_fill_release &&
                              !(i_lu_en && (write_tag == i_fill_release_tag));

    assign o_ex_bypass_en         = i_lu_en;
    assign o_ex_bypass_addr       = i_lu_addr;
    assign o_ex_bypass_tag_select = alloc ? write_select : i_lu_tag_select;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_mhq_valid <= '0;
            o_mhq_head  <= '0;
            o_mhq_tail  <= '0;
        end else begin
            if (o_ex_release_ack) begin
                o_mhq_valid[o_mhq_head] <= 1'b0;
                o_mhq_head              <= o_mhq_head + 1'b1;
            end
            if (alloc) begin
                o_mhq_valid[o_mhq_tail] <= 1'b1;
                o_mhq_tail              <= o_mhq_tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            o_mhq_addr[o_mhq_tail]         <= i_lu_addr;
            o_mhq_byte_updated[o_mhq_tail] <= line_select;
        end else if (merge) begin
            o_mhq_byte_updated[write_tag]  <= o_mhq_byte_updated[write_tag] | line_select;
        end

        if (i_lu_en) begin
            for (int b = 0; b < DC_LINE_BYTES; b++) begin
                if (line_select[b]) begin
                    o_mhq_data[write_tag][b*8 +: 8] <= line_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== verilog/mhq_fill.sv ====
/* Reads the head entry's line over APB, one word per transfer, then releases it.
   The APB port only reads; o_fill_valid is a single-cycle pulse with no ready. */
`timescale 1ns/100ps

module mhq_fill import mhq_pkg::*; (
    input  logic                              clk,
    input  logic                              n_rst,

    input  logic [MHQ_DEPTH-1:0]              i_mhq_valid,
    input  mhq_addr_t [MHQ_DEPTH-1:0]         i_mhq_addr,
    input  cacheline_t [MHQ_DEPTH-1:0]        i_mhq_data,
    input  dc_byte_select_t [MHQ_DEPTH-1:0]   i_mhq_byte_updated,
    input  mhq_tag_t                          i_mhq_head,
    input  logic                              i_ex_release_ack,

    output logic                              o_fill_release,
    output mhq_tag_t                          o_fill_release_tag,

    // APB master
    output addr_t                             o_paddr,
    output logic                              o_psel,
    output logic                              o_penable,
    output logic                              o_pwrite,
    input  data_t                             i_prdata,
    input  logic                              i_pready,

    output logic                              o_fill_valid,
    output mhq_addr_t                         o_fill_addr,
    output cacheline_t                        o_fill_data
);

    fill_state_t state;
    mhq_tag_t    fill_tag;
    mhq_addr_t   fill_addr;
    logic [1:0]  word_idx;
    cacheline_t  line_buf;
    cacheline_t  merged_line;

    assign o_psel             = (state == FILL_SETUP) || (state == FILL_ACCESS);
    assign o_penable          = (state == FILL_ACCESS);
    assign o_pwrite           = 1'b0;
    assign o_paddr            = {fill_addr, word_idx, 2'b00};
    assign o_fill_release     = (state == FILL_DONE);
    assign o_fill_release_tag = fill_tag;

    // Stored bytes win over memory data
    always_comb begin
        for (int b = 0; b < DC_LINE_BYTES; b++) begin
            if (i_mhq_byte_updated[fill_tag][b]) begin
                merged_line[b*8 +: 8] = i_mhq_data[fill_tag][b*8 +: 8];
            end else begin
                merged_line[b*8 +: 8] = line_buf[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state        <= FILL_IDLE;
            o_fill_valid <= 1'b0;
        end else begin
            o_fill_valid <= (state == FILL_DONE) && i_ex_release_ack;
            case (state)
                FILL_IDLE: begin
                    if (i_mhq_valid[i_mhq_head]) begin
                        state <= FILL_SETUP;
                    end
                end
                FILL_SETUP: state <= FILL_ACCESS;
                FILL_ACCESS: begin
                    if (i_pready) begin
                        state <= (word_idx == 2'd3) ? FILL_DONE : FILL_SETUP;
                    end
                end
                FILL_DONE: begin
                    if (i_ex_release_ack) begin
                        state <= FILL_IDLE;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Head entry is latched while idle; it cannot change until released
        if (state == FILL_IDLE) begin
            fill_tag  <= i_mhq_head;
            fill_addr <= i_mhq_addr[i_mhq_head];
            word_idx  <= 2'd0;
        end
        if ((state == FILL_ACCESS) && i_pready) begin
            line_buf[word_idx*DATA_WIDTH +: DATA_WIDTH] <= i_prdata;
            word_idx                                    <= word_idx + 1'b1;
        end
        if ((state == FILL_DONE) && i_ex_release_ack) begin
            o_fill_addr <= fill_addr;
            o_fill_data <= merged_line;
        end
    end

endmodule

// ==== verilog/mhq_lu.sv ====
/* Store data arrives right-justified; halfword stores must be 2-byte aligned
   and word stores 4-byte aligned. Requests seen while full are dropped. */
`timescale 1ns/100ps

module mhq_lu import mhq_pkg::*; (
    input  logic                              clk,
    input  logic                              n_rst,

    // Queue state from the execute stage
    input  logic [MHQ_DEPTH-1:0]              i_mhq_valid,
    input  mhq_addr_t [MHQ_DEPTH-1:0]         i_mhq_addr,
    input  mhq_tag_t                          i_mhq_tail,
    input  logic                              i_mhq_full,

    // Entry being written by the execute stage this cycle
    input  logic                              i_ex_bypass_en,
    input  mhq_addr_t                         i_ex_bypass_addr,
    input  mhq_tag_select_t                   i_ex_bypass_tag_select,

    input  logic                              i_lookup_valid,
    input  logic                              i_lookup_dc_hit,
    input  addr_t                             i_lookup_addr,
    input  lsu_func_t                         i_lookup_func,
    input  data_t                             i_lookup_data,
    input  logic                              i_lookup_we,

    output logic                              o_lu_en,
    output logic                              o_lu_we,
    output dc_offset_t                        o_lu_offset,
    output data_t                             o_lu_wr_data,
    output byte_select_t                      o_lu_byte_select,
    output logic                              o_lu_match,
    output mhq_tag_t                          o_lu_tag,
    output mhq_tag_select_t                   o_lu_tag_select,
    output mhq_addr_t                         o_lu_addr
);

    mhq_addr_t       lookup_addr;
    dc_offset_t      lookup_offset;
    logic            lookup_en;
    logic            bypass_hit;
    logic            lookup_match;
    mhq_tag_select_t match_select;
    mhq_tag_select_t tail_select;
    mhq_tag_select_t lookup_tag_select;
    mhq_tag_t        lookup_tag;
    byte_select_t    lookup_byte_select;
    data_t           lookup_wr_data;

    assign lookup_addr   = i_lookup_addr[ADDR_WIDTH-1:DC_OFFSET_WIDTH];
    assign lookup_offset = i_lookup_addr[DC_OFFSET_WIDTH-1:0];
    assign lookup_en     = i_lookup_valid && !i_lookup_dc_hit && !i_mhq_full;
    assign bypass_hit    = i_ex_bypass_en && (i_ex_bypass_addr == lookup_addr);

    // Search the queue, then pick bypass, match or tail in that order
    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            match_select[i] = i_mhq_valid[i] && (i_mhq_addr[i] == lookup_addr);
            tail_select[i]  = (mhq_tag_t'(i) == i_mhq_tail);
        end
        lookup_match = bypass_hit || (match_select != '0);

        if (bypass_hit) begin
            lookup_tag_select = i_ex_bypass_tag_select;
        end else if (match_select != '0) begin
            lookup_tag_select = match_select;
        end else begin
            lookup_tag_select = tail_select;
        end
    end

    // One-hot select to binary tag
    always_comb begin
        lookup_tag = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (lookup_tag_select[i]) begin
                lookup_tag = mhq_tag_t'(i);
            end
        end
    end

    // Byte lanes within the word come from the low offset bits
    always_comb begin
        lookup_wr_data = i_lookup_data;
        case (i_lookup_func)
            LSU_FUNC_SB: begin
                lookup_byte_select = 4'b0001 << lookup_offset[1:0];
                lookup_wr_data     = i_lookup_data << {lookup_offset[1:0], 3'b000};
            end
            LSU_FUNC_SH: begin
                lookup_byte_select = 4'b0011 << {lookup_offset[1], 1'b0};
                lookup_wr_data     = i_lookup_data << {lookup_offset[1], 4'b0000};
            end
            LSU_FUNC_SW: lookup_byte_select = 4'b1111;
            default:     lookup_byte_select = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_lu_en <= 1'b0;
        end else begin
            o_lu_en <= lookup_en;
        end
    end

    always_ff @(posedge clk) begin
        o_lu_we          <= i_lookup_we;
        o_lu_offset      <= lookup_offset;
        o_lu_wr_data     <= lookup_wr_data;
        o_lu_byte_select <= lookup_byte_select;
        o_lu_match       <= lookup_match;
        o_lu_tag         <= lookup_tag;
        o_lu_tag_select  <= lookup_tag_select;
        o_lu_addr        <= lookup_addr;
    end

endmodule

// ==== verilog/mhq_pkg.sv ====
/* Widths, queue depth and shared types of the miss handling queue.
   A line is four 32-bit words; the queue depth must stay a power of two. */
package mhq_pkg;

    localparam int ADDR_WIDTH      = 32;
    localparam int DATA_WIDTH      = 32;
    localparam int DC_LINE_BYTES   = 16;
    localparam int DC_OFFSET_WIDTH = 4;
    localparam int MHQ_DEPTH       = 4;
    localparam int MHQ_TAG_WIDTH   = 2;

    // Line address has the offset bits stripped
    typedef logic [ADDR_WIDTH-DC_OFFSET_WIDTH-1:0] mhq_addr_t;
    typedef logic [ADDR_WIDTH-1:0]                 addr_t;
    typedef logic [DATA_WIDTH-1:0]                 data_t;
    typedef logic [DC_OFFSET_WIDTH-1:0]            dc_offset_t;
    typedef logic [DATA_WIDTH/8-1:0]               byte_select_t;
    typedef logic [DC_LINE_BYTES-1:0]              dc_byte_select_t;
    typedef logic [MHQ_TAG_WIDTH-1:0]              mhq_tag_t;
    typedef logic [MHQ_DEPTH-1:0]                  mhq_tag_select_t;
    typedef logic [DC_LINE_BYTES*8-1:0]            cacheline_t;

    // Load/store unit function codes seen on the lookup port
    typedef enum logic [2:0] {
        LSU_FUNC_LB = 3'd0,
        LSU_FUNC_LH = 3'd1,
        LSU_FUNC_LW = 3'd2,
        LSU_FUNC_SB = 3'd3,
        LSU_FUNC_SH = 3'd4,
        LSU_FUNC_SW = 3'd5
    } lsu_func_t;

    typedef enum logic [1:0] {
        FILL_IDLE   = 2'd0,
        FILL_SETUP  = 2'd1,
        FILL_ACCESS = 2'd2,
        FILL_DONE   = 2'd3
    } fill_state_t;

endpackage

// ==== verilog/mhq_top.sv ====
/* Miss handling queue: lookup, execute and fill stages. The requester must
   hold off while o_mhq_full is high; every fill must be taken by the cache. */
`timescale 1ns/100ps

module mhq_top import mhq_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,

    input  logic       i_lookup_valid,
    input  logic       i_lookup_dc_hit,
    input  addr_t      i_lookup_addr,
    input  lsu_func_t  i_lookup_func,
    input  data_t      i_lookup_data,
    input  logic       i_lookup_we,
    output logic       o_mhq_full,

    output addr_t      o_paddr,
    output logic       o_psel,
    output logic       o_penable,
    output logic       o_pwrite,
    input  data_t      i_prdata,
    input  logic       i_pready,

    output logic       o_fill_valid,
    output mhq_addr_t  o_fill_addr,
    output cacheline_t o_fill_data
);

    logic                            lu_en;
    logic                            lu_we;
    dc_offset_t                      lu_offset;
    data_t                           lu_wr_data;
    byte_select_t                    lu_byte_select;
    logic                            lu_match;
    mhq_tag_t                        lu_tag;
    mhq_tag_select_t                 lu_tag_select;
    mhq_addr_t                       lu_addr;
    logic [MHQ_DEPTH-1:0]            mhq_valid;
    mhq_addr_t [MHQ_DEPTH-1:0]       mhq_addr;
    cacheline_t [MHQ_DEPTH-1:0]      mhq_data;
    dc_byte_select_t [MHQ_DEPTH-1:0] mhq_byte_updated;
    mhq_tag_t                        mhq_tail;
    mhq_tag_t                        mhq_head;
    logic                            ex_bypass_en;
    mhq_addr_t                       ex_bypass_addr;
    mhq_tag_select_t                 ex_bypass_tag_select;
    logic                            ex_release_ack;
    logic                            fill_release;
    mhq_tag_t                        fill_release_tag;

    mhq_lu u_mhq_lu (
        .clk(clk), .n_rst(n_rst),
        .i_mhq_valid(mhq_valid), .i_mhq_addr(mhq_addr), .i_mhq_tail(mhq_tail),
        .i_mhq_full(o_mhq_full),
        .i_ex_bypass_en(ex_bypass_en), .i_ex_bypass_addr(ex_bypass_addr),
        .i_ex_bypass_tag_select(ex_bypass_tag_select),
        .i_lookup_valid(i_lookup_valid), .i_lookup_dc_hit(i_lookup_dc_hit),
        .i_lookup_addr(i_lookup_addr), .i_lookup_func(i_lookup_func),
        .i_lookup_data(i_lookup_data), .i_lookup_we(i_lookup_we),
        .o_lu_en(lu_en), .o_lu_we(lu_we), .o_lu_offset(lu_offset),
        .o_lu_wr_data(lu_wr_data), .o_lu_byte_select(lu_byte_select),
        .o_lu_match(lu_match), .o_lu_tag(lu_tag), .o_lu_tag_select(lu_tag_select),
        .o_lu_addr(lu_addr)
    );

    mhq_ex u_mhq_ex (
        .clk(clk), .n_rst(n_rst),
        .i_lu_en(lu_en), .i_lu_we(lu_we), .i_lu_offset(lu_offset),
        .i_lu_wr_data(lu_wr_data), .i_lu_byte_select(lu_byte_select),
        .i_lu_match(lu_match), .i_lu_tag(lu_tag), .i_lu_tag_select(lu_tag_select),
        .i_lu_addr(lu_addr),
        .i_fill_release(fill_release), .i_fill_release_tag(fill_release_tag),
        .o_mhq_valid(mhq_valid), .o_mhq_addr(mhq_addr), .o_mhq_data(mhq_data),
        .o_mhq_byte_updated(mhq_byte_updated), .o_mhq_tail(mhq_tail),
        .o_mhq_head(mhq_head), .o_mhq_full(o_mhq_full),
        .o_ex_bypass_en(ex_bypass_en), .o_ex_bypass_addr(ex_bypass_addr),
        .o_ex_bypass_tag_select(ex_bypass_tag_select),
        .o_ex_release_ack(ex_release_ack)
    );

    mhq_fill u_mhq_fill (
        .clk(clk), .n_rst(n_rst),
        .i_mhq_valid(mhq_valid), .i_mhq_addr(mhq_addr), .i_mhq_data(mhq_data),
        .i_mhq_byte_updated(mhq_byte_updated), .i_mhq_head(mhq_head),
        .i_ex_release_ack(ex_release_ack),
        .o_fill_release(fill_release), .o_fill_release_tag(fill_release_tag),
        .o_paddr(o_paddr), .o_psel(o_psel), .o_penable(o_penable), .o_pwrite(o_pwrite),
        .i_prdata(i_prdata), .i_pready(i_pready),
        .o_fill_valid(o_fill_valid), .o_fill_addr(o_fill_addr), .o_fill_data(o_fill_data)
    );

endmodule
